// ==== logic/uart_pkg.sv ====
// shared widths, register map, constants and state encodings; imported by every uart block
`default_nettype none

package uart_pkg;

	// --------------------
	// serial format
	// --------------------
	localparam int DATA_BITS  = 8;   // fixed, no parity
	localparam int OVERSAMPLE = 16;  // ticks per bit
	localparam int TICK_W     = $clog2(OVERSAMPLE);
	localparam int RX_CNT_W   = $clog2(OVERSAMPLE + OVERSAMPLE / 2); // must hold 1.5 bits

	localparam int RX_FIFO_DEPTH = 4; // power of two, pointers wrap by themselves
	localparam int FIFO_AW       = $clog2(RX_FIFO_DEPTH);

	typedef logic [DATA_BITS-1:0]         uart_byte_t;
	typedef logic [$clog2(DATA_BITS)-1:0] bit_idx_t;
	typedef logic [TICK_W-1:0]            tick_cnt_t;
	typedef logic [RX_CNT_W-1:0]          rx_cnt_t;
	typedef logic [15:0]                  baud_div_t;
	typedef logic [FIFO_AW-1:0]           fifo_ptr_t;
	typedef logic [FIFO_AW:0]             fifo_cnt_t; // one extra bit for full

	localparam tick_cnt_t TICK_LAST     = tick_cnt_t'(OVERSAMPLE - 1);
	localparam rx_cnt_t   RX_FIRST_WAIT = rx_cnt_t'(OVERSAMPLE + OVERSAMPLE / 2 - 1); // edge to mid bit0
	localparam rx_cnt_t   RX_BIT_WAIT   = rx_cnt_t'(OVERSAMPLE - 1); // mid bit to mid bit
	localparam fifo_cnt_t FIFO_FULL_CNT = fifo_cnt_t'(RX_FIFO_DEPTH);
	localparam baud_div_t DIV_RESET     = 16'd3;

	// --------------------
	// axi4-lite register map
	// --------------------
	typedef logic [3:0]  axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	localparam axi_addr_t ADDR_DATA   = 4'h0; // write sends, read pops
	localparam axi_addr_t ADDR_STATUS = 4'h4; // write 1 to clear sticky bits
	localparam axi_addr_t ADDR_DIV    = 4'h8;
	localparam axi_addr_t ADDR_CTRL   = 4'hC;

	// status bit positions
	localparam int ST_RX_VALID  = 0;
	localparam int ST_RX_FULL   = 1;
	localparam int ST_TX_BUSY   = 2;
	localparam int ST_OVERRUN   = 3; // sticky
	localparam int ST_FRAME_ERR = 4; // sticky

	// ctrl bit positions
	localparam int CTRL_EN   = 0;
	localparam int CTRL_LOOP = 1;

	// --------------------
	// state machines
	// --------------------
	typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;
	typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
	typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

`default_nettype wire

// ==== logic/uart_baud_gen.sv ====
// oversample tick generator; one tick every baud_div+1 clocks while enabled, feeds tx and rx
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                enable,   // ctrl enable bit
	input  uart_pkg::baud_div_t baud_div, // from div register
	output logic                tick      // one clk wide
);
	import uart_pkg::*;

	baud_div_t cnt; // down counter, tick at zero

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= DIV_RESET;
		end else if (!enable) begin
			cnt <= baud_div; // parked at reload value
		end else if (cnt == '0) begin
			cnt <= baud_div; // new divisor only picked up here
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// div of 0 gives a tick on every clk
	assign tick = enable && (cnt == '0);

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// uart receiver; 16x oversampled line in, byte out with one-cycle done or frame error pulse
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 tick,         // oversample tick
	input  logic                 rxd,          // async serial line
	output uart_pkg::uart_byte_t rx_data,      // valid with rx_done
	output logic                 rx_done,      // good stop bit
	output logic                 rx_frame_err  // low stop bit, byte dropped
);
	import uart_pkg::*;

	logic                rxd_meta; // first sync stage
	logic                rxd_sync;
	logic                rxd_prev; // for edge detect
	logic                busy;     // frame in progress
	rx_cnt_t             cnt;      // ticks to next sample
	logic [DATA_BITS:0]  sh;       // {data, marker}, marker walks down to bit 0
	logic                start_edge;
	logic                do_sample;
	logic                stop_sample;

	// --------------------
	// line sync and edge
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1; // idle line is high
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	// falling edge only counts while idle
	assign start_edge = !busy && rxd_prev && !rxd_sync;
	assign do_sample  = busy && tick && (cnt == '0);

	// --------------------
	// sample timing
	// --------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start_edge) begin
			busy <= 1'b1;
			cnt  <= RX_FIRST_WAIT; // skip start bit, land mid bit0
		end else if (do_sample) begin
			cnt <= RX_BIT_WAIT;
			if (sh[0]) begin
				busy <= 1'b0; // that was the stop bit
			end
		end else if (busy && tick) begin
			cnt <= cnt - 1'b1;
		end
	end

	// shift in lsb first, marker seeded at the top
	always_ff @(posedge clk) begin
		if (start_edge) begin
			sh <= {1'b1, {DATA_BITS{1'b0}}};
		end else if (do_sample && !sh[0]) begin
			sh <= {rxd_sync, sh[DATA_BITS:1]};
		end
	end

	assign rx_data = sh[DATA_BITS:1];

	// marker at bottom, this sample is the stop bit
	// pulses come half a bit before the stop bit ends
	assign stop_sample  = do_sample && sh[0];
	assign rx_done      = stop_sample && rxd_sync;
	assign rx_frame_err = stop_sample && !rxd_sync;

	// fifo push and error flag must never see both for one frame
	a_done_xor_err: assert property (@(posedge clk) disable iff (!rst_n)
		!(rx_done && rx_frame_err));

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// uart transmitter; one start bit, eight data bits lsb first, one stop bit per tx_start pulse
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 tick,     // oversample tick
	input  logic                 tx_start, // one cycle, only when idle
	input  uart_pkg::uart_byte_t tx_data,
	output logic                 txd,
	output logic                 tx_busy
);
	import uart_pkg::*;

	tx_state_t  state;
	tick_cnt_t  tick_cnt; // ticks into the current bit
	bit_idx_t   bit_idx;  // data bit being sent
	uart_byte_t shreg;    // shifts right, bit 0 on the line
	logic       bit_end;

	assign bit_end = tick && (tick_cnt == TICK_LAST);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			tick_cnt <= '0;
			bit_idx  <= '0;
		end else begin
			if (state == IDLE) begin
				tick_cnt <= '0;
			end else if (tick) begin
				tick_cnt <= tick_cnt + 1'b1; // wraps to 0 at bit end
			end
			case (state)
				IDLE: begin
					if (tx_start) begin
						state <= START;
					end
				end
				START: begin
					if (bit_end) begin
						state   <= DATA;
						bit_idx <= '0;
					end
				end
				DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == bit_idx_t'(DATA_BITS - 1)) begin
							state <= STOP;
						end
					end
				end
				default: begin // stop bit
					if (bit_end) begin
						state <= IDLE;
					end
				end
			endcase
		end
	end

	// byte register, loaded on start
	always_ff @(posedge clk) begin
		if (state == IDLE && tx_start) begin
			shreg <= tx_data;
		end else if (state == DATA && bit_end) begin
			shreg <= shreg >> 1;
		end
	end

	always_comb begin
		case (state)
			START:   txd = 1'b0;
			DATA:    txd = shreg[0];
			default: txd = 1'b1; // idle and stop
		endcase
	end

	assign tx_busy = (state != IDLE);

	// register side has to wait for busy to drop before sending again
	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== logic/uart_rx_fifo.sv ====
// receive fifo; holds bytes from the receiver until software pops them through the data register
`timescale 1ns/100ps
`default_nettype none

module uart_rx_fifo (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 push,      // rx_done that may arrive when full
	input  uart_pkg::uart_byte_t push_data,
	input  logic                 pop,       // completed data read
	output uart_pkg::uart_byte_t pop_data,  // oldest entry
	output logic                 empty,
	output logic                 full
);
	import uart_pkg::*;

	uart_byte_t mem [RX_FIFO_DEPTH];
	fifo_ptr_t  wr_ptr;
	fifo_ptr_t  rd_ptr;
	fifo_cnt_t  count;
	logic       do_push; // push that actually lands
	logic       do_pop;

	assign do_push = push && !full; // dropped when full and regs flags overrun
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // natural wrap
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign pop_data = mem[rd_ptr];
	assign empty    = (count == '0);
	assign full     = (count == FIFO_FULL_CNT);

	// regs only pops after a read that saw data
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

	// pointer distance tracks the count and wraps to zero when full
	a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n)
		fifo_ptr_t'(wr_ptr - rd_ptr) == fifo_ptr_t'(count));

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
// axi4-lite register block; data, status, divisor and ctrl registers, sticky flags, loopback mux
`timescale 1ns/100ps
`default_nettype none

module uart_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 awvalid,
	output logic                 awready,
	input  uart_pkg::axi_addr_t  awaddr,
	input  logic                 wvalid,
	output logic                 wready,
	input  uart_pkg::axi_data_t  wdata,
	input  logic [3:0]           wstrb,    // strobes not supported, full word writes
	output logic                 bvalid,
	input  logic                 bready,
	output uart_pkg::axi_resp_t  bresp,
	input  logic                 arvalid,
	output logic                 arready,
	input  uart_pkg::axi_addr_t  araddr,
	output logic                 rvalid,
	input  logic                 rready,
	output uart_pkg::axi_data_t  rdata,
	output uart_pkg::axi_resp_t  rresp,
	output uart_pkg::baud_div_t  baud_div,
	output logic                 enable,
	output logic                 tx_start,
	output uart_pkg::uart_byte_t tx_data,
	input  logic                 tx_busy,
	input  logic                 txd_loop,  // own txd for loopback
	input  logic                 rxd_ext,   // pin
	output logic                 rx_line,   // to receiver
	input  logic                 rx_done,
	input  logic                 rx_frame_err,
	output logic                 fifo_pop,
	input  uart_pkg::uart_byte_t fifo_data,
	input  logic                 fifo_empty,
	input  logic                 fifo_full
);
	import uart_pkg::*;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic      ctrl_loop;
	logic      overrun;     // sticky
	logic      frame_err;   // sticky
	logic      rd_pop_pend; // read in flight holds a real fifo byte
	logic      wr_fire;
	logic      rd_fire;
	logic      rd_done;
	logic      tx_blocked;
	logic      sts_clr;
	axi_data_t status_word;
	axi_data_t rd_word;

	// --------------------
	// write channel
	// --------------------
	assign wr_fire    = (wr_state == WR_IDLE) && awvalid && wvalid; // addr and data together
	assign awready    = wr_fire;
	assign wready     = wr_fire;
	assign bvalid     = (wr_state == WR_RESP);
	assign tx_blocked = tx_busy || tx_start; // covers the cycle before busy rises
	assign sts_clr    = wr_fire && (awaddr == ADDR_STATUS);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state  <= WR_IDLE;
			bresp     <= RESP_OKAY;
			baud_div  <= DIV_RESET;
			enable    <= 1'b0;
			ctrl_loop <= 1'b0;
			tx_start  <= 1'b0;
		end else begin
			tx_start <= 1'b0; // single pulse
			if (wr_fire) begin
				wr_state <= WR_RESP;
				bresp    <= RESP_OKAY;
				case (awaddr)
					ADDR_DATA: begin
						if (tx_blocked) begin
							bresp <= RESP_SLVERR; // byte dropped
						end else begin
							tx_start <= enable; // disabled block drops it quietly
						end
					end
					ADDR_STATUS: bresp <= RESP_OKAY; // w1c below
					ADDR_DIV:    baud_div <= wdata[$bits(baud_div_t)-1:0];
					ADDR_CTRL: begin
						enable    <= wdata[CTRL_EN];
						ctrl_loop <= wdata[CTRL_LOOP];
					end
					default: bresp <= RESP_SLVERR; // unmapped
				endcase
			end else if (bvalid && bready) begin
				wr_state <= WR_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && awaddr == ADDR_DATA && !tx_blocked) begin
			tx_data <= wdata[DATA_BITS-1:0];
		end
	end

	// sticky flags, a new event wins over a clear
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overrun   <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			if (rx_done && fifo_full) begin
				overrun <= 1'b1;
			end else if (sts_clr && wdata[ST_OVERRUN]) begin
				overrun <= 1'b0;
			end
			if (rx_frame_err) begin
				frame_err <= 1'b1;
			end else if (sts_clr && wdata[ST_FRAME_ERR]) begin
				frame_err <= 1'b0;
			end
		end
	end

	// --------------------
	// read channel
	// --------------------
	assign arready  = (rd_state == RD_IDLE);
	assign rvalid   = (rd_state == RD_DATA);
	assign rd_fire  = arvalid && arready;
	assign rd_done  = rvalid && rready;
	assign rresp    = RESP_OKAY; // reads never fail
	assign fifo_pop = rd_done && rd_pop_pend;

	always_comb begin
		status_word               = '0;
		status_word[ST_RX_VALID]  = !fifo_empty;
		status_word[ST_RX_FULL]   = fifo_full;
		status_word[ST_TX_BUSY]   = tx_blocked;
		status_word[ST_OVERRUN]   = overrun;
		status_word[ST_FRAME_ERR] = frame_err;
	end

	always_comb begin
		rd_word = '0; // unmapped reads zero
		case (araddr)
			ADDR_DATA:   rd_word = fifo_empty ? '0 : axi_data_t'(fifo_data);
			ADDR_STATUS: rd_word = status_word;
			ADDR_DIV:    rd_word = axi_data_t'(baud_div);
			ADDR_CTRL: begin
				rd_word[CTRL_EN]   = enable;
				rd_word[CTRL_LOOP] = ctrl_loop;
			end
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state    <= RD_IDLE;
			rd_pop_pend <= 1'b0;
		end else if (rd_fire) begin
			rd_state    <= RD_DATA;
			rd_pop_pend <= (araddr == ADDR_DATA) && !fifo_empty;
		end else if (rd_done) begin
			rd_state    <= RD_IDLE;
			rd_pop_pend <= 1'b0;
		end
	end

	// held until rready, head entry cannot move meanwhile
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_word;
		end
	end

	assign rx_line = ctrl_loop ? txd_loop : rxd_ext;

	// response must wait for the master
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bvalid && !bready) |=> bvalid);

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
// uart peripheral top; axi4-lite register block driving baud generator, tx, rx and receive fifo
`timescale 1ns/100ps
`default_nettype none

module uart_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                awvalid,
	output logic                awready,
	input  uart_pkg::axi_addr_t awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  uart_pkg::axi_data_t wdata,
	input  logic [3:0]          wstrb,
	output logic                bvalid,
	input  logic                bready,
	output uart_pkg::axi_resp_t bresp,
	input  logic                arvalid,
	output logic                arready,
	input  uart_pkg::axi_addr_t araddr,
	output logic                rvalid,
	input  logic                rready,
	output uart_pkg::axi_data_t rdata,
	output uart_pkg::axi_resp_t rresp,
	input  logic                rxd,
	output logic                txd
);
	import uart_pkg::*;

	baud_div_t  baud_div;
	logic       enable;
	logic       tick;     // shared oversample tick
	logic       tx_start;
	uart_byte_t tx_data;
	logic       tx_busy;
	logic       rx_line;  // pin or loopback
	uart_byte_t rx_data;
	logic       rx_done;
	logic       rx_frame_err;
	logic       fifo_pop;
	uart_byte_t fifo_data;
	logic       fifo_empty;
	logic       fifo_full;

	uart_regs i_regs (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.baud_div(baud_div), .enable(enable),
		.tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy),
		.txd_loop(txd), .rxd_ext(rxd), .rx_line(rx_line),
		.rx_done(rx_done), .rx_frame_err(rx_frame_err),
		.fifo_pop(fifo_pop), .fifo_data(fifo_data),
		.fifo_empty(fifo_empty), .fifo_full(fifo_full)
	);

	uart_baud_gen i_baud (
		.clk(clk), .rst_n(rst_n), .enable(enable), .baud_div(baud_div), .tick(tick)
	);

	uart_tx i_tx (
		.clk(clk), .rst_n(rst_n), .tick(tick), .tx_start(tx_start),
		.tx_data(tx_data), .txd(txd), .tx_busy(tx_busy)
	);

	uart_rx i_rx (
		.clk(clk), .rst_n(rst_n), .tick(tick), .rxd(rx_line),
		.rx_data(rx_data), .rx_done(rx_done), .rx_frame_err(rx_frame_err)
	);

	// push straight from rx, fifo drops it when full
	uart_rx_fifo i_fifo (
		.clk(clk), .rst_n(rst_n), .push(rx_done), .push_data(rx_data),
		.pop(fifo_pop), .pop_data(fifo_data), .empty(fifo_empty), .full(fifo_full)
	);

endmodule

`default_nettype wire

// ==== verif/uart_tb.sv ====
// testbench for uart_top; axi4-lite register traffic, serial line model and reference checks
`timescale 1ns/100ps
`default_nettype none

module uart_tb;
	import uart_pkg::*;

	localparam int TEST_DIV  = 1;                          // divisor used by the test
	localparam int BIT_CLKS  = OVERSAMPLE * (TEST_DIV + 1); // 32 clk per bit
	localparam int HS_TO     = 50;                         // handshake wait limit in cycles
	localparam int FRAME_TO  = 2000;                       // start bit wait limit
	localparam int POLL_TO   = 200;                        // status polls before giving up

	logic      clk;
	logic      rst_n;
	logic      awvalid, awready, wvalid, wready, bvalid, bready;
	axi_addr_t awaddr, araddr;
	axi_data_t wdata, rdata;
	logic [3:0] wstrb;
	axi_resp_t bresp, rresp;
	logic      arvalid, arready, rvalid, rready;
	logic      rxd, txd;

	logic [31:0] lfsr_state;

	// reference model state
	uart_byte_t m_fifo[$];
	baud_div_t  m_div;
	logic       m_en, m_loop, m_overrun, m_frame_err, m_tx_busy;

	// pending compares drained on the rising edge
	string       chk_name[$];
	logic [31:0] chk_got[$];
	logic [31:0] chk_exp[$];

	uart_top i_uart_top (
		.clk(clk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.rxd(rxd), .txd(txd)
	);

	always #10 clk = ~clk; // 20 ns period

	// --------------------
	// helpers
	// --------------------
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1); // right shifting galois step
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	task automatic queue_check(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_name.push_back(name);
		chk_got.push_back(got);
		chk_exp.push_back(exp);
	endtask

	always @(posedge clk) begin : compare_proc
		string       nm;
		logic [31:0] g;
		logic [31:0] e;
		while (chk_name.size() != 0) begin
			nm = chk_name.pop_front();
			g  = chk_got.pop_front();
			e  = chk_exp.pop_front();
			assert (g === e) else begin
				$display("ERROR at %0t: %s = %h, expected %h", $time, nm, g, e);
				stop_with_failure("a DUT output differs from the reference model");
			end
		end
	end

	// --------------------
	// reference model
	// --------------------
	function automatic axi_data_t ref_read(input axi_addr_t addr);
		axi_data_t v;
		v = '0; // unmapped reads zero
		case (addr)
			ADDR_DATA: begin
				if (m_fifo.size() != 0) begin
					v = axi_data_t'(m_fifo[0]);
				end
			end
			ADDR_STATUS: begin
				v[ST_RX_VALID]  = (m_fifo.size() != 0);
				v[ST_RX_FULL]   = (m_fifo.size() == RX_FIFO_DEPTH);
				v[ST_TX_BUSY]   = m_tx_busy;
				v[ST_OVERRUN]   = m_overrun;
				v[ST_FRAME_ERR] = m_frame_err;
			end
			ADDR_DIV: v = axi_data_t'(m_div);
			ADDR_CTRL: begin
				v[CTRL_EN]   = m_en;
				v[CTRL_LOOP] = m_loop;
			end
			default: v = '0;
		endcase
		return v;
	endfunction

	function automatic axi_resp_t ref_wresp(input axi_addr_t addr);
		case (addr)
			ADDR_DATA:   return m_tx_busy ? RESP_SLVERR : RESP_OKAY; // one byte in flight
			ADDR_STATUS: return RESP_OKAY;
			ADDR_DIV:    return RESP_OKAY;
			ADDR_CTRL:   return RESP_OKAY;
			default:     return RESP_SLVERR;
		endcase
	endfunction

	// what one received frame does to the model
	function automatic void model_rx(input uart_byte_t b, input logic stop);
		if (!stop) begin
			m_frame_err = 1'b1; // nothing pushed
		end else if (m_fifo.size() == RX_FIFO_DEPTH) begin
			m_overrun = 1'b1;   // byte lost
		end else begin
			m_fifo.push_back(b);
		end
	endfunction

	// --------------------
	// axi4-lite master
	// --------------------
	task automatic write_word(input axi_addr_t addr, input axi_data_t data, output axi_resp_t resp);
		int          n;
		logic [31:0] r;
		@(negedge clk);
		queue_check("awready", 32'(awready), 32'd0); // nothing offered yet
		queue_check("wready", 32'(wready), 32'd0);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		while (bvalid !== 1'b1) begin // accepted the cycle before bvalid
			if (n >= HS_TO) stop_with_failure("write was never accepted");
			@(negedge clk);
			n++;
		end
		// still offered but the response is pending
		queue_check("awready", 32'(awready), 32'd0);
		queue_check("wready", 32'(wready), 32'd0);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		take_bits(2, r); // 0..3 cycles of back-pressure
		repeat (r) begin
			@(negedge clk);
			queue_check("bvalid", 32'(bvalid), 32'd1);
		end
		bready = 1'b1;
		resp   = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_word(input axi_addr_t addr, output axi_data_t data, output axi_resp_t resp);
		int          n;
		logic [31:0] r;
		axi_data_t   first;
		@(negedge clk);
		queue_check("arready", 32'(arready), 32'd1); // no response pending
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		while (rvalid !== 1'b1) begin
			if (n >= HS_TO) stop_with_failure("read data never came back");
			@(negedge clk);
			n++;
		end
		queue_check("arready", 32'(arready), 32'd0); // response now pending
		arvalid = 1'b0;
		first   = rdata;
		take_bits(2, r);
		repeat (r) begin // data must hold while stalled
			@(negedge clk);
			queue_check("rvalid", 32'(rvalid), 32'd1);
			queue_check("rdata held", rdata, first);
		end
		rready = 1'b1;
		data   = rdata;
		resp   = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic read_and_check(input axi_addr_t addr, input string name);
		axi_data_t exp;
		axi_data_t got;
		axi_resp_t resp;
		exp = ref_read(addr);
		read_word(addr, got, resp);
		queue_check({name, " rdata"}, got, exp);
		queue_check({name, " rresp"}, 32'(resp), 32'(RESP_OKAY));
		if (addr == ADDR_DATA && m_fifo.size() != 0) begin
			void'(m_fifo.pop_front()); // completed data read pops
		end
	endtask

	task automatic write_and_check(input axi_addr_t addr, input axi_data_t data, input string name);
		axi_resp_t exp;
		axi_resp_t got;
		exp = ref_wresp(addr);
		write_word(addr, data, got);
		queue_check({name, " bresp"}, 32'(got), 32'(exp));
		case (addr)
			ADDR_DATA:   m_tx_busy = m_tx_busy || (exp == RESP_OKAY && m_en);
			ADDR_STATUS: begin // write 1 to clear
				if (data[ST_OVERRUN]) m_overrun = 1'b0;
				if (data[ST_FRAME_ERR]) m_frame_err = 1'b0;
			end
			ADDR_DIV: m_div = data[15:0];
			ADDR_CTRL: begin
				m_en   = data[CTRL_EN];
				m_loop = data[CTRL_LOOP];
			end
			default: ; // slverr leaves the state alone
		endcase
	endtask

	task automatic wait_tx_idle();
		int        n;
		axi_data_t st;
		axi_resp_t r;
		n = 0;
		read_word(ADDR_STATUS, st, r);
		while (st[ST_TX_BUSY]) begin
			if (n >= POLL_TO) stop_with_failure("transmitter stayed busy");
			read_word(ADDR_STATUS, st, r);
			n++;
		end
		m_tx_busy = 1'b0;
	endtask

	// --------------------
	// serial line model
	// --------------------
	task automatic send_frame(input uart_byte_t b, input logic stop);
		@(negedge clk);
		rxd = 1'b0; // start
		repeat (BIT_CLKS) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			rxd = b[i]; // lsb first
			repeat (BIT_CLKS) @(negedge clk);
		end
		rxd = stop;
		repeat (BIT_CLKS) @(negedge clk);
		rxd = 1'b1;
	endtask

	task automatic receive_frame(output uart_byte_t b);
		int n;
		n = 0;
		while (txd !== 1'b0) begin
			if (n >= FRAME_TO) stop_with_failure("no start bit appeared on txd");
			@(negedge clk);
			n++;
		end
		repeat (BIT_CLKS / 2) @(negedge clk); // middle of start bit
		queue_check("txd start bit", 32'(txd), 32'd0);
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			b[i] = txd;
		end
		repeat (BIT_CLKS) @(negedge clk);
		queue_check("txd stop bit", 32'(txd), 32'd1);
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		logic [31:0] r;
		uart_byte_t  b;
		uart_byte_t  b2;
		uart_byte_t  got;
		int          n;
		int          low_cnt;
		clk = 1'b0;
		rst_n = 1'b0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		rxd = 1'b1; // idle line
		lfsr_state = 32'h2faf_bb24;
		m_fifo.delete();
		m_div = DIV_RESET;
		{m_en, m_loop, m_overrun, m_frame_err, m_tx_busy} = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// registers after reset, readback, unmapped access
		read_and_check(ADDR_STATUS, "status after reset");
		read_and_check(ADDR_DIV, "div after reset");
		read_and_check(ADDR_CTRL, "ctrl after reset");
		write_and_check(ADDR_DIV, 32'h0000_5a3c, "div");
		read_and_check(ADDR_DIV, "div readback");
		write_and_check(ADDR_DIV, 32'(TEST_DIV), "div");
		write_and_check(ADDR_CTRL, 32'h1, "ctrl enable");
		read_and_check(ADDR_CTRL, "ctrl readback");
		read_and_check(ADDR_DIV, "div readback");
		write_and_check(4'h2, 32'hdead_beef, "unmapped");
		read_and_check(4'h6, "unmapped read");

		// transmit random bytes
		repeat (3) begin
			take_bits(8, r);
			b = r[7:0];
			fork
				write_and_check(ADDR_DATA, 32'(b), "data write");
				receive_frame(got);
			join
			queue_check("txd byte", 32'(got), 32'(b));
			wait_tx_idle();
		end

		// second write while busy is refused and never sent
		take_bits(8, r);
		b = r[7:0];
		take_bits(8, r);
		b2 = r[7:0];
		fork
			begin
				write_and_check(ADDR_DATA, 32'(b), "data write");
				repeat (40) @(negedge clk);
				write_and_check(ADDR_DATA, 32'(b2), "data write while busy");
			end
			receive_frame(got);
		join
		queue_check("txd byte", 32'(got), 32'(b));
		wait_tx_idle();
		low_cnt = 0;
		repeat (11 * BIT_CLKS) begin
			@(negedge clk);
			if (txd !== 1'b1) low_cnt++;
		end
		queue_check("txd low samples after refused write", 32'(low_cnt), 32'd0);

		// receive random frames
		repeat (3) begin
			take_bits(8, r);
			b = r[7:0];
			send_frame(b, 1'b1);
			model_rx(b, 1'b1);
		end
		read_and_check(ADDR_STATUS, "status rx valid");
		repeat (3) read_and_check(ADDR_DATA, "rx data");
		read_and_check(ADDR_STATUS, "status rx drained");

		// overrun two frames past full
		repeat (RX_FIFO_DEPTH + 2) begin
			take_bits(8, r);
			b = r[7:0];
			send_frame(b, 1'b1);
			model_rx(b, 1'b1);
		end
		read_and_check(ADDR_STATUS, "status overrun");
		repeat (RX_FIFO_DEPTH + 1) read_and_check(ADDR_DATA, "rx data after overrun");
		write_and_check(ADDR_STATUS, 32'(1) << ST_OVERRUN, "clear overrun");
		read_and_check(ADDR_STATUS, "status overrun cleared");

		// low stop bit
		take_bits(8, r);
		b = r[7:0];
		send_frame(b, 1'b0);
		model_rx(b, 1'b0);
		read_and_check(ADDR_STATUS, "status frame error");
		read_and_check(ADDR_DATA, "rx data after frame error");
		write_and_check(ADDR_STATUS, 32'(1) << ST_FRAME_ERR, "clear frame error");
		read_and_check(ADDR_STATUS, "status frame error cleared");

		// internal loopback with the pin held low
		write_and_check(ADDR_CTRL, 32'h3, "ctrl loopback");
		rxd = 1'b0;
		repeat (2) begin
			take_bits(8, r);
			b = r[7:0];
			write_and_check(ADDR_DATA, 32'(b), "loopback write");
			wait_tx_idle(); // rx finishes half a bit earlier
			model_rx(b, 1'b1);
			read_and_check(ADDR_DATA, "loopback data");
		end
		read_and_check(ADDR_STATUS, "status after loopback");

		n = 0;
		while (chk_name.size() != 0) begin
			if (n >= 10) stop_with_failure("pending compares were never processed");
			@(negedge clk);
			n++;
		end
		$display("Done: no errors");
		$finish;
	end

	// overall limit
	initial begin : watchdog
		repeat (200000) @(posedge clk);
		stop_with_failure("simulation ran past its cycle limit");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_rx_fifo.sv
logic/uart_regs.sv
logic/uart_top.sv
verif/uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uart testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module uart_tb -f verilog.f -o uart_sim \
	> build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "FAIL: verilator build failed"
	exit 1
fi

./obj_dir/uart_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "FAIL: simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL: pass message not found in sim.log"
exit 1
